/* hdl/video_types_pkg.sv */
`default_nettype none

// Widths shared by every stage of the raster generator
package video_types_pkg;

	////////////////////////////////////////
	// Raster geometry
	////////////////////////////////////////

	localparam int COORD_W = 11;    // Up to 2047 columns or lines

	// Column, line or timing threshold
	typedef logic [COORD_W-1:0] coord_t;

	////////////////////////////////////////
	// Front panel format switch
	////////////////////////////////////////

	localparam int SW_CODE_W = 4;   // Four slide switches

	// Raw or synchronized switch setting
	typedef logic [SW_CODE_W-1:0] sw_code_t;

endpackage

`default_nettype wire

/* hdl/display_modes_pkg.sv */
`default_nettype none

// Display formats and their timing
package display_modes_pkg;

	////////////////////////////////////////
	// Switch codes
	////////////////////////////////////////

	localparam video_types_pkg::sw_code_t SW_VGA      = 4'b0000;
	localparam video_types_pkg::sw_code_t SW_SVGA     = 4'b0001;
	localparam video_types_pkg::sw_code_t SW_XGA      = 4'b0011;
	localparam video_types_pkg::sw_code_t SW_HDTV720P = 4'b0010;
	localparam video_types_pkg::sw_code_t SW_SXGA     = 4'b1000;
	localparam video_types_pkg::sw_code_t SW_CAMERA   = 4'b1001;

	////////////////////////////////////////
	// Table rows
	////////////////////////////////////////

	localparam int NUM_FORMATS = 6;

	typedef logic [2:0] fmt_idx_t;   // Row number in the timing table

	localparam fmt_idx_t FMT_VGA      = 3'd0;   // 640x480
	localparam fmt_idx_t FMT_SVGA     = 3'd1;   // 800x600
	localparam fmt_idx_t FMT_XGA      = 3'd2;   // 1024x768
	localparam fmt_idx_t FMT_HDTV720P = 3'd3;   // 1280x720
	localparam fmt_idx_t FMT_SXGA     = 3'd4;   // 1280x1024
	localparam fmt_idx_t FMT_CAMERA   = 3'd5;   // 1280x720 with trimmed porches

	// Columns in row order                   VGA     SVGA    XGA      720p     SXGA     CAMERA
	localparam video_types_pkg::coord_t H_LIVE [NUM_FORMATS] =
		'{11'd640, 11'd800, 11'd1024, 11'd1280, 11'd1280, 11'd1280};
	localparam video_types_pkg::coord_t H_FP [NUM_FORMATS] =
		'{11'd16, 11'd40, 11'd24, 11'd110, 11'd48, 11'd110};   // Front porch
	localparam video_types_pkg::coord_t H_SW [NUM_FORMATS] =
		'{11'd96, 11'd128, 11'd136, 11'd40, 11'd112, 11'd39};  // Sync pulse width
	localparam video_types_pkg::coord_t H_BP [NUM_FORMATS] =
		'{11'd48, 11'd88, 11'd160, 11'd220, 11'd248, 11'd220}; // Back porch

	// Vertical values in lines
	localparam video_types_pkg::coord_t V_LIVE [NUM_FORMATS] =
		'{11'd480, 11'd600, 11'd768, 11'd720, 11'd1024, 11'd720};
	localparam video_types_pkg::coord_t V_FP [NUM_FORMATS] =
		'{11'd10, 11'd1, 11'd3, 11'd5, 11'd1, 11'd4};
	localparam video_types_pkg::coord_t V_SW [NUM_FORMATS] =
		'{11'd2, 11'd4, 11'd6, 11'd5, 11'd3, 11'd4};
	localparam video_types_pkg::coord_t V_BP [NUM_FORMATS] =
		'{11'd33, 11'd23, 11'd29, 11'd20, 11'd38, 11'd22};

	// Both syncs active low
	localparam logic SYNC_NEG [NUM_FORMATS] =
		'{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

	////////////////////////////////////////
	// Auxiliary data read window
	////////////////////////////////////////

	localparam video_types_pkg::coord_t AUX_H_FIRST       = 11'd1559;  // 32 column slot
	localparam video_types_pkg::coord_t AUX_H_LAST        = 11'd1590;
	localparam video_types_pkg::coord_t AUX_SPECIAL_LINE  = 11'd725;
	localparam video_types_pkg::coord_t AUX_SPECIAL_FIRST = 11'd9;     // Wide slot on that line
	localparam video_types_pkg::coord_t AUX_SPECIAL_LAST  = 11'd200;

	// Switch code to table row, unknown codes fall back to 720p
	function automatic fmt_idx_t fmt_index(input video_types_pkg::sw_code_t code);
		case (code)
			SW_VGA:    return FMT_VGA;
			SW_SVGA:   return FMT_SVGA;
			SW_XGA:    return FMT_XGA;
			SW_SXGA:   return FMT_SXGA;
			SW_CAMERA: return FMT_CAMERA;
			default:   return FMT_HDTV720P;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hdl/mode_select.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_select #(
	parameter int SETTLE_CYCLES = 1000   // Cycles a new code must hold
) (
	input  wire logic                      clk50m_bufg,
	input  wire logic                      RSTBTN,
	input  wire video_types_pkg::sw_code_t sw,
	output video_types_pkg::coord_t        h_blank_start,
	output video_types_pkg::coord_t        h_sync_start,
	output video_types_pkg::coord_t        h_sync_end,
	output video_types_pkg::coord_t        h_total_end,
	output video_types_pkg::coord_t        v_blank_start,
	output video_types_pkg::coord_t        v_sync_start,
	output video_types_pkg::coord_t        v_sync_end,
	output video_types_pkg::coord_t        v_total_end,
	output logic                           sync_negative,
	output logic                           restart
);

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);
	localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(SETTLE_CYCLES - 1);

	typedef enum logic [1:0] {WATCH, SETTLE, LOAD} state_t;

	state_t                    state;
	video_types_pkg::sw_code_t sw_meta, sw_sync;   // Two flop synchronizer
	video_types_pkg::sw_code_t cand_code;          // Code being timed
	video_types_pkg::sw_code_t applied_code;       // Code driving the raster
	logic [CNT_W-1:0]          settle_cnt;
	logic                      enter_load;
	display_modes_pkg::fmt_idx_t row_idx;
	video_types_pkg::coord_t   h_live, h_fp, h_sw, h_bp;
	video_types_pkg::coord_t   v_live, v_fp, v_sw, v_bp;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= display_modes_pkg::SW_HDTV720P;
			sw_sync <= display_modes_pkg::SW_HDTV720P;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	////////////////////////////////////////
	// Settling FSM
	////////////////////////////////////////

	assign enter_load = (state == SETTLE) && (sw_sync == cand_code) &&
		(settle_cnt == SETTLE_LAST);
	assign restart = (state == LOAD);   // Same cycle as the new thresholds

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state        <= SETTLE;   // Whatever the switch shows gets applied
			cand_code    <= display_modes_pkg::SW_HDTV720P;
			applied_code <= display_modes_pkg::SW_HDTV720P;
			settle_cnt   <= '0;
		end else begin
			case (state)
				WATCH: begin
					if (sw_sync != applied_code) begin
						state      <= SETTLE;
						cand_code  <= sw_sync;
						settle_cnt <= '0;
					end
				end
				SETTLE: begin
					if (sw_sync != cand_code) begin
						// Glitch, start timing again
						cand_code  <= sw_sync;
						settle_cnt <= '0;
						if (sw_sync == applied_code)
							state <= WATCH;   // Back to where we were
					end else if (enter_load) begin
						state        <= LOAD;
						applied_code <= cand_code;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				LOAD:    state <= WATCH;
				default: state <= WATCH;
			endcase
		end
	end

	////////////////////////////////////////
	// Threshold registers
	////////////////////////////////////////

	assign row_idx = RSTBTN ? display_modes_pkg::FMT_HDTV720P :
		display_modes_pkg::fmt_index(cand_code);

	always_comb begin
		h_live = display_modes_pkg::H_LIVE[row_idx];
		h_fp   = display_modes_pkg::H_FP[row_idx];
		h_sw   = display_modes_pkg::H_SW[row_idx];
		h_bp   = display_modes_pkg::H_BP[row_idx];
		v_live = display_modes_pkg::V_LIVE[row_idx];
		v_fp   = display_modes_pkg::V_FP[row_idx];
		v_sw   = display_modes_pkg::V_SW[row_idx];
		v_bp   = display_modes_pkg::V_BP[row_idx];
	end

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || enter_load) begin
			h_blank_start <= h_live - 11'd1;                    // Last live pixel
			h_sync_start  <= h_live - 11'd1 + h_fp;
			h_sync_end    <= h_live - 11'd1 + h_fp + h_sw;
			h_total_end   <= h_live - 11'd1 + h_fp + h_sw + h_bp;
			v_blank_start <= v_live - 11'd1;
			v_sync_start  <= v_live - 11'd1 + v_fp;
			v_sync_end    <= v_live - 11'd1 + v_fp + v_sw;
			v_total_end   <= v_live - 11'd1 + v_fp + v_sw + v_bp;
			sync_negative <= display_modes_pkg::SYNC_NEG[row_idx];
		end
	end

	restart_single: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		restart |=> !restart)
		else $error("restart held for two cycles");

	// Timers rely on this order for their compares
	thresholds_ordered: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		(h_blank_start < h_sync_start) && (h_sync_start < h_sync_end) &&
		(h_sync_end < h_total_end) && (v_blank_start < v_sync_start) &&
		(v_sync_start < v_sync_end) && (v_sync_end < v_total_end))
		else $error("timing thresholds out of order");

endmodule

`default_nettype wire

/* hdl/line_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_timer (
	input  wire logic                    clk50m_bufg,
	input  wire logic                    RSTBTN,
	input  wire logic                    restart,        // New format loaded
	input  wire video_types_pkg::coord_t h_blank_start,
	input  wire video_types_pkg::coord_t h_sync_start,
	input  wire video_types_pkg::coord_t h_sync_end,
	input  wire video_types_pkg::coord_t h_total_end,
	output video_types_pkg::coord_t      hcount,
	output logic                         h_blank,
	output logic                         h_sync_raw,
	output logic                         line_end
);

	////////////////////////////////////////
	// Pixel counter
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart)
			hcount <= '0;
		else if (line_end)
			hcount <= '0;             // Wrap after the back porch
		else
			hcount <= hcount + 1'b1;
	end

	assign line_end = (hcount == h_total_end);

	// Flags straight off the count
	assign h_blank    = (hcount > h_blank_start);
	assign h_sync_raw = (hcount > h_sync_start) && (hcount <= h_sync_end);   // Before polarity

	// Count is zeroed the edge after a restart
	hcount_in_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!restart |-> (hcount <= h_total_end))
		else $error("hcount %0d beyond h_total_end %0d", hcount, h_total_end);

endmodule

`default_nettype wire

/* hdl/frame_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_timer (
	input  wire logic                    clk50m_bufg,
	input  wire logic                    RSTBTN,
	input  wire logic                    restart,
	input  wire logic                    line_end,       // Last pixel of a line
	input  wire video_types_pkg::coord_t v_blank_start,
	input  wire video_types_pkg::coord_t v_sync_start,
	input  wire video_types_pkg::coord_t v_sync_end,
	input  wire video_types_pkg::coord_t v_total_end,
	output video_types_pkg::coord_t      vcount,
	output logic                         v_blank,
	output logic                         v_sync_raw
);

	////////////////////////////////////////
	// Line counter
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			vcount <= '0;
		end else if (line_end) begin
			if (vcount == v_total_end)
				vcount <= '0;         // New frame
			else
				vcount <= vcount + 1'b1;
		end
	end

	// Same compares as the horizontal side
	assign v_blank    = (vcount > v_blank_start);
	assign v_sync_raw = (vcount > v_sync_start) && (vcount <= v_sync_end);

	// Thresholds change with restart, count follows one edge later
	vcount_in_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!restart |-> (vcount <= v_total_end))
		else $error("vcount %0d beyond v_total_end %0d", vcount, v_total_end);

endmodule

`default_nettype wire

/* hdl/sync_combiner.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_combiner (
	input  wire logic                    clk50m_bufg,
	input  wire logic                    RSTBTN,
	input  wire logic                    sync_negative,   // Flip both syncs
	input  wire video_types_pkg::coord_t hcount,
	input  wire video_types_pkg::coord_t vcount,
	input  wire logic                    h_blank,
	input  wire logic                    v_blank,
	input  wire logic                    h_sync_raw,
	input  wire logic                    v_sync_raw,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         de,
	output logic                         aux_en
);

	logic active_q;
	logic hsync_q, vsync_q;
	logic in_window;

	////////////////////////////////////////
	// Two stage sync and DE path
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			active_q <= 1'b0;
			hsync_q  <= 1'b0;
			vsync_q  <= 1'b0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			de       <= 1'b0;
		end else begin
			active_q <= !h_blank && !v_blank;       // Live pixel
			hsync_q  <= h_sync_raw ^ sync_negative;
			vsync_q  <= v_sync_raw ^ sync_negative;
			hsync    <= hsync_q;                    // Second stage
			vsync    <= vsync_q;
			de       <= active_q;
		end
	end

	////////////////////////////////////////
	// Aux data read window
	////////////////////////////////////////

	always_comb begin
		if ((vcount == display_modes_pkg::AUX_SPECIAL_LINE) && !v_blank) begin
			// Wide slot early in the special line
			in_window = (hcount >= display_modes_pkg::AUX_SPECIAL_FIRST) &&
				(hcount <= display_modes_pkg::AUX_SPECIAL_LAST);
		end else begin
			in_window = (hcount >= display_modes_pkg::AUX_H_FIRST) &&
				(hcount <= display_modes_pkg::AUX_H_LAST);   // Past the live width
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN)
			aux_en <= 1'b0;
		else
			aux_en <= in_window;   // One cycle behind the counters
	end

	// de trails aux_en by one cycle for the same counter state
	aux_off_live: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		aux_en && ($past(vcount) != display_modes_pkg::AUX_SPECIAL_LINE) |=> !de)
		else $error("aux_en window overlaps de");

endmodule

`default_nettype wire

/* hdl/video_timing_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing_top #(
	parameter int SETTLE_CYCLES = 1000   // About 20 us at 50 MHz
) (
	input  wire logic                      clk50m_bufg,
	input  wire logic                      RSTBTN,
	input  wire video_types_pkg::sw_code_t sw,        // Format switch, asynchronous
	output wire logic                      hsync,
	output wire logic                      vsync,
	output wire logic                      de,
	output wire logic                      aux_en,
	output wire video_types_pkg::coord_t   hcount,
	output wire video_types_pkg::coord_t   vcount
);

	wire video_types_pkg::coord_t h_blank_start, h_sync_start, h_sync_end, h_total_end;
	wire video_types_pkg::coord_t v_blank_start, v_sync_start, v_sync_end, v_total_end;
	wire logic sync_negative;
	wire logic restart;
	wire logic h_blank, h_sync_raw, line_end;
	wire logic v_blank, v_sync_raw;

	////////////////////////////////////////
	// Format selection
	////////////////////////////////////////

	mode_select #(
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) mode_select_inst (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.sw           (sw),
		.h_blank_start(h_blank_start),
		.h_sync_start (h_sync_start),
		.h_sync_end   (h_sync_end),
		.h_total_end  (h_total_end),
		.v_blank_start(v_blank_start),
		.v_sync_start (v_sync_start),
		.v_sync_end   (v_sync_end),
		.v_total_end  (v_total_end),
		.sync_negative(sync_negative),
		.restart      (restart)
	);

	////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////

	line_timer line_timer_inst (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.restart      (restart),
		.h_blank_start(h_blank_start),
		.h_sync_start (h_sync_start),
		.h_sync_end   (h_sync_end),
		.h_total_end  (h_total_end),
		.hcount       (hcount),
		.h_blank      (h_blank),
		.h_sync_raw   (h_sync_raw),
		.line_end     (line_end)
	);

	frame_timer frame_timer_inst (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.restart      (restart),
		.line_end     (line_end),
		.v_blank_start(v_blank_start),
		.v_sync_start (v_sync_start),
		.v_sync_end   (v_sync_end),
		.v_total_end  (v_total_end),
		.vcount       (vcount),
		.v_blank      (v_blank),
		.v_sync_raw   (v_sync_raw)
	);

	// Outputs two cycles behind the counters, aux_en one
	sync_combiner sync_combiner_inst (
		.clk50m_bufg  (clk50m_bufg),
		.RSTBTN       (RSTBTN),
		.sync_negative(sync_negative),
		.hcount       (hcount),
		.vcount       (vcount),
		.h_blank      (h_blank),
		.v_blank      (v_blank),
		.h_sync_raw   (h_sync_raw),
		.v_sync_raw   (v_sync_raw),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.aux_en       (aux_en)
	);

endmodule

`default_nettype wire

/* test/tb_video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_timing;

	localparam int SETTLE_CYCLES   = 1000;    // Same as the top level default
	localparam int SETTLE_MARGIN   = 3 + 5;   // Synchronizer and FSM, then restart edges
	localparam int RESET_CYCLES    = 5;
	localparam int NUM_ROWS        = 7;
	localparam int NUM_GLITCHES    = 4;
	localparam int MAX_GLITCH      = 50;
	localparam int REF_TOTAL       = 1650;    // 720p line, used by the glitch test
	localparam int AUX_FIRST       = 1559;    // First column of the aux slot
	localparam int AUX_WIDTH       = 32;
	localparam int VGA_VSYNC_LINES = 2;
	localparam logic [3:0] GLITCH_CODE = 4'b0000;

	////////////////////////////////////////
	// Test table
	////////////////////////////////////////

	// Rows are VGA, SVGA, XGA, 720p, SXGA, camera, then an unknown code
	localparam logic [3:0] ROW_CODE [NUM_ROWS] =
		'{4'b0000, 4'b0001, 4'b0011, 4'b0010, 4'b1000, 4'b1001, 4'b0111};
	// Live + front porch + sync + back porch
	localparam int ROW_TOTAL [NUM_ROWS] = '{800, 1056, 1344, 1650, 1688, 1649, 1650};
	localparam int ROW_LIVE  [NUM_ROWS] = '{640, 800, 1024, 1280, 1280, 1280, 1280};
	localparam int ROW_HSW   [NUM_ROWS] = '{96, 128, 136, 40, 112, 39, 40};
	localparam logic ROW_NEG [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
	localparam int ROW_LINES [NUM_ROWS] = '{525, 628, 806, 750, 1066, 750, 750};

	logic        clk50m_bufg;
	logic        RSTBTN;
	logic [3:0]  sw;
	logic        hsync, vsync, de, aux_en;
	logic [10:0] hcount, vcount;

	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] rng_state = 32'd21;   // Seed for glitch lengths

	video_timing_top #(
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) video_timing_top_inst (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.aux_en     (aux_en),
		.hcount     (hcount),
		.vcount     (vcount)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;   // 50 MHz
	end

	// Watchdog
	always @(posedge clk50m_bufg) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: run still busy after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Every test phase, plus ten percent
	function automatic int timeout_cycles();
		int sum;
		int r;
		sum = RESET_CYCLES + 8;
		for (r = 0; r < NUM_ROWS; r++)
			sum += SETTLE_CYCLES + SETTLE_MARGIN + 4 * ROW_TOTAL[r];
		sum += NUM_GLITCHES * (MAX_GLITCH + SETTLE_CYCLES + SETTLE_MARGIN + 2 * REF_TOTAL);
		sum += REF_TOTAL;                                             // Line sync before glitches
		sum += SETTLE_CYCLES + SETTLE_MARGIN + 2 * ROW_TOTAL[0] * ROW_LINES[0];   // VGA frames
		return sum + sum / 10;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("Failure: %s", what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAILED with %0d errors", tests_run, name,
				errors - errors_at_start);
		end
	endtask

	// Stops on the falling edge where hcount first reads 0
	task automatic wait_line_start();
		@(negedge clk50m_bufg);
		while (hcount == 11'd0)
			@(negedge clk50m_bufg);
		while (hcount != 11'd0)
			@(negedge clk50m_bufg);
	endtask

	////////////////////////////////////////
	// Per format line checks
	////////////////////////////////////////

	task automatic measure_format(input int r);
		int          k, n_samples, exp_aux, exp_vc;
		int          rise_a, rise_b, hs_fall, de_rise, aux_rise, aux_rises;
		logic        exp_neg, hs_act, hs_prev, de_prev, aux_prev;
		logic [10:0] hc_d1, hc_d2, vc_prev;
		errors_at_start = errors;
		exp_neg = ROW_NEG[r];
		@(negedge clk50m_bufg);
		sw = ROW_CODE[r];
		repeat (SETTLE_CYCLES + SETTLE_MARGIN) @(negedge clk50m_bufg);
		wait_line_start();   // Skip the line cut by restart

		// Sample 0 sits at hcount 0, outputs still show the blanked tail
		if (hsync !== exp_neg)
			report_mismatch("hsync idle level", int'(exp_neg), int'(hsync));
		if (vcount !== 11'd1)   // Line 0 began at the restart
			report_mismatch("vcount after restart", 1, int'(vcount));
		n_samples = 2 * ROW_TOTAL[r] + 4;
		hc_d1 = hcount;
		hc_d2 = hcount;
		vc_prev = vcount;
		hs_prev = hsync ^ exp_neg;
		de_prev = de;
		aux_prev = aux_en;
		rise_a = -1;
		rise_b = -1;
		hs_fall = -1;
		de_rise = -1;
		aux_rise = -1;
		aux_rises = 0;
		for (k = 1; k < n_samples; k++) begin
			@(negedge clk50m_bufg);
			hs_act = hsync ^ exp_neg;   // Active level as high
			if (hs_act && !hs_prev) begin
				if (rise_a < 0)
					rise_a = k;
				else if (rise_b < 0)
					rise_b = k;
			end
			if (!hs_act && hs_prev && rise_a >= 0 && hs_fall < 0) begin
				hs_fall = k;
				if (k - rise_a != ROW_HSW[r])
					report_mismatch("hsync width", ROW_HSW[r], k - rise_a);
			end
			if (de && !de_prev) begin
				de_rise = k;
				if (hc_d2 != 11'd0)   // Two cycle output delay
					report_mismatch("hcount at de rise", 0, int'(hc_d2));
			end
			if (!de && de_prev && de_rise >= 0 && k - de_rise != ROW_LIVE[r])
				report_mismatch("de width", ROW_LIVE[r], k - de_rise);
			if (aux_en && !aux_prev) begin
				aux_rise = k;
				aux_rises++;
				if (int'(hc_d1) != AUX_FIRST)   // One cycle delay
					report_mismatch("hcount at aux_en rise", AUX_FIRST, int'(hc_d1));
			end
			if (!aux_en && aux_prev && aux_rise >= 0 && k - aux_rise != AUX_WIDTH)
				report_mismatch("aux_en width", AUX_WIDTH, k - aux_rise);
			if (aux_en && de)
				report_failure($sformatf("aux_en and de high together at hcount %0d", hcount));
			// Steps once per line, no frame wrap this early
			exp_vc = (hcount == 11'd0) ? int'(vc_prev) + 1 : int'(vc_prev);
			if (int'(vcount) != exp_vc)
				report_mismatch("vcount", exp_vc, int'(vcount));
			hc_d2 = hc_d1;
			hc_d1 = hcount;
			vc_prev = vcount;
			hs_prev = hs_act;
			de_prev = de;
			aux_prev = aux_en;
		end

		if (rise_b < 0)
			report_failure("fewer than two hsync pulses in two lines");
		else if (rise_b - rise_a != ROW_TOTAL[r])
			report_mismatch("hsync period", ROW_TOTAL[r], rise_b - rise_a);
		if (de_rise < 0)
			report_failure("de never rose on a live line");
		// Slot only reached by lines long enough to hold it
		exp_aux = (ROW_TOTAL[r] >= AUX_FIRST + AUX_WIDTH) ? 2 : 0;
		if (aux_rises != exp_aux)
			report_mismatch("aux_en pulses", exp_aux, aux_rises);
		finish_test($sformatf("format sw=%b", ROW_CODE[r]));
	endtask

	////////////////////////////////////////
	// Switch glitch and VGA frame
	////////////////////////////////////////

	task automatic glitch_test();
		int          g, k, len, steps, t, last_zero, exp_hc;
		logic [10:0] hc_prev;
		errors_at_start = errors;
		wait_line_start();   // Raster is 720p from the last table row
		t = 0;
		last_zero = 0;
		hc_prev = hcount;
		for (g = 0; g < NUM_GLITCHES; g++) begin
			rng_state = xorshift32(rng_state);
			len = 5 + int'(rng_state % 32'd46);   // 5 to 50 cycles
			steps = len + SETTLE_CYCLES + SETTLE_MARGIN + 2 * REF_TOTAL;
			sw = GLITCH_CODE;
			for (k = 0; k < steps; k++) begin
				@(negedge clk50m_bufg);
				t++;
				if (k == len - 1)
					sw = ROW_CODE[NUM_ROWS - 1];   // Back to the applied code
				exp_hc = (int'(hc_prev) == REF_TOTAL - 1) ? 0 : int'(hc_prev) + 1;
				if (int'(hcount) != exp_hc)
					report_mismatch("hcount", exp_hc, int'(hcount));
				if (hcount == 11'd0) begin
					if (t - last_zero != REF_TOTAL)
						report_mismatch("hcount line length", REF_TOTAL, t - last_zero);
					last_zero = t;
				end
				hc_prev = hcount;
			end
		end
		finish_test("switch glitch rejection");
	endtask

	task automatic vsync_test();
		int   k, rise_a, rise_b, fall_a, exp_width, exp_period;
		logic act, prev;
		errors_at_start = errors;
		exp_width = VGA_VSYNC_LINES * ROW_TOTAL[0];
		exp_period = ROW_LINES[0] * ROW_TOTAL[0];
		sw = ROW_CODE[0];
		repeat (SETTLE_CYCLES + SETTLE_MARGIN) @(negedge clk50m_bufg);
		if (vsync !== 1'b1)   // Idle high at negative polarity
			report_mismatch("vsync idle level", 1, int'(vsync));
		k = 0;
		rise_a = -1;
		rise_b = -1;
		fall_a = -1;
		prev = !vsync;
		while (rise_b < 0) begin
			@(negedge clk50m_bufg);
			k++;
			act = !vsync;
			if (act && !prev) begin
				if (rise_a < 0)
					rise_a = k;
				else
					rise_b = k;
			end
			if (!act && prev && rise_a >= 0 && fall_a < 0)
				fall_a = k;
			if (aux_en && de)
				report_failure("aux_en and de high together during the VGA frame");
			prev = act;
		end
		if (fall_a - rise_a != exp_width)
			report_mismatch("vsync width", exp_width, fall_a - rise_a);
		if (rise_b - rise_a != exp_period)
			report_mismatch("vsync period", exp_period, rise_b - rise_a);
		finish_test("VGA vsync");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int r;
		RSTBTN = 1'b1;
		sw = ROW_CODE[3];   // 720p, same as the reset default
		cycle_limit = timeout_cycles();
		repeat (RESET_CYCLES) @(negedge clk50m_bufg);
		RSTBTN = 1'b0;

		for (r = 0; r < NUM_ROWS; r++)
			measure_format(r);
		glitch_test();
		vsync_test();

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
hdl/video_types_pkg.sv
hdl/display_modes_pkg.sv
hdl/mode_select.sv
hdl/line_timer.sv
hdl/frame_timer.sv
hdl/sync_combiner.sv
hdl/video_timing_top.sv
test/tb_video_timing.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_video_timing \
	-Mdir obj_dir \
	-o sim_video_timing \
	-f filelist.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_video_timing > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
